// File: source/aesPkg.sv
// shared types and constants for the AES-128 encryption core
// byte 0 of a block sits in the top bits and a column is four consecutive bytes
package aesPkg;

	// one state byte
	typedef logic [7:0] byteT;

	// one column of the state, or one word of a key
	typedef logic [31:0] wordT;

	// full state, cipher key or round key
	typedef logic [127:0] blockT;

	// round counter, wide enough for rounds 1 to 10
	typedef logic [3:0] roundT;

	typedef enum logic {
		seqIdle,
		seqRun
	} seqStateT;

	// fixed by AES-128, the core does not support other key sizes
	localparam int numRounds = 10;

	// round constant of round 1, later ones come from repeated doubling
	localparam byteT rconFirst = 8'h01;

	// multiply by 2 in GF(2^8)
	// when the top bit falls off, reduce by the AES polynomial x^8+x^4+x^3+x+1
	function automatic byteT xtime(input byteT b);
		byteT shifted;
		shifted = {b[6:0], 1'b0};
		if (b[7]) begin
			shifted = shifted ^ 8'h1b;
		end
		return shifted;
	endfunction

endpackage

// File: source/sbox.sv
// forward AES substitution box, purely combinational
// the high nibble picks a row of sixteen entries and the low nibble picks the byte
module sbox (
	input aesPkg::byteT in,
	output aesPkg::byteT out
);

	// one row of the table, entry 0 in the top byte
	logic [127:0] row;

	always_comb begin
		case (in[7:4])
			4'h0: row = 128'h637c777b_f26b6fc5_3001672b_fed7ab76;
			4'h1: row = 128'hca82c97d_fa5947f0_add4a2af_9ca472c0;
			4'h2: row = 128'hb7fd9326_363ff7cc_34a5e5f1_71d83115;
			4'h3: row = 128'h04c723c3_1896059a_071280e2_eb27b275;
			4'h4: row = 128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84;
			4'h5: row = 128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf;
			4'h6: row = 128'hd0efaafb_434d3385_45f9027f_503c9fa8;
			4'h7: row = 128'h51a3408f_929d38f5_bcb6da21_10fff3d2;
			4'h8: row = 128'hcd0c13ec_5f974417_c4a77e3d_645d1973;
			4'h9: row = 128'h60814fdc_222a9088_46eeb814_de5e0bdb;
			4'ha: row = 128'he0323a0a_4906245c_c2d3ac62_9195e479;
			4'hb: row = 128'he7c8376d_8dd54ea9_6c56f4ea_657aae08;
			4'hc: row = 128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a;
			4'hd: row = 128'h703eb566_4803f60e_613557b9_86c11d9e;
			4'he: row = 128'he1f89811_69d98e94_9b1e87e9_ce5528df;
			4'hf: row = 128'h8ca1890d_bfe64268_41992d0f_b054bb16;
			default: row = '0;
		endcase
	end

	// entry n lives at bits 127-8n down to 120-8n, so invert the nibble to get the offset
	assign out = row[{~in[3:0], 3'b000} +: 8];

endmodule

// File: source/roundTransform.sv
// one AES round without the key addition, combinational with zero latency
// MixColumns is skipped while lastRound is high
module roundTransform (
	input aesPkg::blockT state,
	input logic lastRound,
	output aesPkg::blockT transformed
);

	import aesPkg::*;

	// byte n of each stage, row is n mod 4 and column is n div 4
	byteT subBytes [16];
	byteT shifted [16];
	byteT mixed [16];

	genvar i;
	genvar c;
	genvar r;

	// SubBytes
	generate
		for (i = 0; i < 16; i++) begin : subStage
			sbox subBox (
				.in(state[127 - 8 * i -: 8]),
				.out(subBytes[i])
			);
		end
	endgenerate

	// ShiftRows rotates row r left by r columns
	generate
		for (c = 0; c < 4; c++) begin : shiftCol
			for (r = 0; r < 4; r++) begin : shiftRow
				assign shifted[4 * c + r] = subBytes[4 * ((c + r) % 4) + r];
			end
		end
	endgenerate

	// MixColumns with the fixed matrix 2 3 1 1 / 1 2 3 1 / 1 1 2 3 / 3 1 1 2
	// a factor of 3 is the doubled byte XOR the byte itself
	generate
		for (c = 0; c < 4; c++) begin : mixCol
			byteT a0;
			byteT a1;
			byteT a2;
			byteT a3;
			assign a0 = shifted[4 * c];
			assign a1 = shifted[4 * c + 1];
			assign a2 = shifted[4 * c + 2];
			assign a3 = shifted[4 * c + 3];
			assign mixed[4 * c] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
			assign mixed[4 * c + 1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
			assign mixed[4 * c + 2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
			assign mixed[4 * c + 3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
		end
	endgenerate

	// pack the bytes back, byte 0 into the top bits
	generate
		for (i = 0; i < 16; i++) begin : packStage
			assign transformed[127 - 8 * i -: 8] = lastRound ? shifted[i] : mixed[i];
		end
	endgenerate

endmodule

// File: source/keySchedule.sv
// AES-128 key expansion, one round key per step
// roundKey is registered and valid one edge after load or step
// load wins over step when both are high
module keySchedule (
	input logic clk,
	input logic rst,
	input logic load,
	input logic step,
	input aesPkg::blockT key,
	output aesPkg::blockT roundKey
);

	import aesPkg::*;

	blockT srcKey;
	wordT w0;
	wordT w1;
	wordT w2;
	wordT w3;
	wordT rotWord;
	wordT subWord;
	wordT temp;
	wordT n0;
	wordT n1;
	wordT n2;
	wordT n3;
	byteT rconReg;
	byteT rconUse;

	genvar j;

	// expand from the cipher key on load, otherwise from the key of the last round
	assign srcKey = load ? key : roundKey;
	assign w0 = srcKey[127:96];
	assign w1 = srcKey[95:64];
	assign w2 = srcKey[63:32];
	assign w3 = srcKey[31:0];

	// RotWord then SubWord on the last word
	assign rotWord = {w3[23:0], w3[31:24]};

	generate
		for (j = 0; j < 4; j++) begin : subWordStage
			sbox keyBox (
				.in(rotWord[31 - 8 * j -: 8]),
				.out(subWord[31 - 8 * j -: 8])
			);
		end
	endgenerate

	// rconReg holds the constant of the key now in roundKey
	assign rconUse = load ? rconFirst : xtime(rconReg);
	assign temp = subWord ^ {rconUse, 24'h000000};

	// each word chains off the one before it
	assign n0 = w0 ^ temp;
	assign n1 = w1 ^ n0;
	assign n2 = w2 ^ n1;
	assign n3 = w3 ^ n2;

	always_ff @(posedge clk) begin
		if (rst) begin
			rconReg <= rconFirst;
		end else if (load || step) begin
			rconReg <= rconUse;
		end
	end

	always_ff @(posedge clk) begin
		if (load || step) begin
			roundKey <= {n0, n1, n2, n3};
		end
	end

endmodule

// File: source/roundSequencer.sv
// round control for the iterative cipher, one round per clock
// inclk is accepted while idle or in the last round, and ignored otherwise
// outclk pulses ten edges after the accepting edge, out holds until the next result
module roundSequencer (
	input logic clk,
	input logic rst,
	input logic inclk,
	input aesPkg::blockT in,
	input aesPkg::blockT key,
	input aesPkg::blockT roundKey,
	input aesPkg::blockT transformed,
	output aesPkg::blockT state,
	output logic lastRound,
	output logic load,
	output logic step,
	output logic outclk,
	output aesPkg::blockT out
);

	import aesPkg::*;

	seqStateT seq;
	roundT round;
	blockT nextState;

	// round holds the number of the round being computed in this cycle
	assign lastRound = (seq == seqRun) && (round == roundT'(numRounds));

	// the machine already knows it goes idle after the last round, so take a new block then
	assign load = inclk && ((seq == seqIdle) || lastRound);
	assign step = (seq == seqRun);

	// AddRoundKey on the output of the round transform
	assign nextState = transformed ^ roundKey;

	always_ff @(posedge clk) begin
		if (rst) begin
			seq <= seqIdle;
			round <= '0;
			outclk <= 1'b0;
			out <= '0;
		end else begin
			outclk <= lastRound;
			if (lastRound) begin
				out <= nextState;
			end
			if (load) begin
				seq <= seqRun;
				round <= roundT'(1);
			end else if (lastRound) begin
				seq <= seqIdle;
			end else if (seq == seqRun) begin
				round <= round + roundT'(1);
			end
		end
	end

	// initial key addition on load, then one full round per edge
	always_ff @(posedge clk) begin
		if (load) begin
			state <= in ^ key;
		end else if (step) begin
			state <= nextState;
		end
	end

endmodule

// File: source/aesEncrypt.sv
// AES-128 encryption, one block in flight and no back-pressure
// a block takes ten clocks from inclk to outclk, and inclk during that time is dropped
module aesEncrypt (
	input logic clk,
	input logic rst,
	input logic inclk,
	input aesPkg::blockT in,
	input aesPkg::blockT key,
	output logic outclk,
	output aesPkg::blockT out
);

	import aesPkg::*;

	blockT state;
	blockT roundKey;
	blockT transformed;
	logic lastRound;
	logic load;
	logic step;

	roundSequencer roundSequencer_inst (
		.clk(clk),
		.rst(rst),
		.inclk(inclk),
		.in(in),
		.key(key),
		.roundKey(roundKey),
		.transformed(transformed),
		.state(state),
		.lastRound(lastRound),
		.load(load),
		.step(step),
		.outclk(outclk),
		.out(out)
	);

	keySchedule keySchedule_inst (
		.clk(clk),
		.rst(rst),
		.load(load),
		.step(step),
		.key(key),
		.roundKey(roundKey)
	);

	roundTransform roundTransform_inst (
		.state(state),
		.lastRound(lastRound),
		.transformed(transformed)
	);

endmodule

// File: bench/aesEncrypt_chk.sv
// strobe timing checks bound into the round sequencer
// load is high in the cycle that an inclk is accepted
module aesEncrypt_chk (
	input logic clk,
	input logic rst,
	input logic load,
	input logic outclk
);

	// number of assertion failures so far
	int failures = 0;

	// the result pulse lasts a single cycle
	pulseOneCycle: assert property (
		@(posedge clk) disable iff (rst) outclk |=> !outclk
	) else begin
		$error("outclk stayed high for two cycles in a row");
		failures++;
	end

	// the pulse register is cleared by reset
	pulseLowAfterReset: assert property (
		@(posedge clk) rst |=> !outclk
	) else begin
		$error("outclk was high in the cycle after reset");
		failures++;
	end

	// outclk rises at the tenth edge after acceptance, so it is sampled high one edge later
	pulseAfterLoad: assert property (
		@(posedge clk) disable iff (rst) load |-> ##10 !outclk ##1 outclk
	) else begin
		$error("outclk did not rise exactly ten edges after an accepted block");
		failures++;
	end

endmodule

bind roundSequencer aesEncrypt_chk seqChk (
	.clk(clk),
	.rst(rst),
	.load(load),
	.outclk(outclk)
);

// File: bench/aesEncryptTb.sv
// directed testbench for the AES-128 encryption core against the FIPS-197 vectors
// outputs are sampled on the falling edge and inputs change on the rising edge
module aesEncryptTb;

	import aesPkg::*;

	// appendix C.1 vector
	localparam blockT keyC = 128'h000102030405060708090a0b0c0d0e0f;
	localparam blockT plainC = 128'h00112233445566778899aabbccddeeff;
	localparam blockT cipherC = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

	// appendix B vector
	localparam blockT keyB = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam blockT plainB = 128'h3243f6a8885a308d313198a2e0370734;
	localparam blockT cipherB = 128'h3925841d02dc09fbdc118597196a0b32;

	// reset plus five tests of at most about 30 cycles each
	localparam int maxCycles = 200;

	// a block is accepted at one edge and its pulse is seen after the tenth edge that follows
	localparam int blockEdges = 10;

	logic clk;
	logic rst;
	logic inclk;
	blockT plainIn;
	blockT keyIn;
	logic outclk;
	blockT cipherOut;

	int cycleCount = 0;
	int testErrors = 0;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	string waitName = "reset release";

	aesEncrypt aesEncrypt_inst (
		.clk(clk),
		.rst(rst),
		.inclk(inclk),
		.in(plainIn),
		.key(keyIn),
		.outclk(outclk),
		.out(cipherOut)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		while (cycleCount < maxCycles) begin
			@(posedge clk);
			cycleCount = cycleCount + 1;
		end
		$display("timeout after %0d cycles, still waiting for %s", cycleCount, waitName);
		$display("tests failed");
		$finish;
	end

	task automatic compareBlock(input string testName, input blockT expected, input blockT actual);
		if (expected !== actual) begin
			testErrors++;
			$display("ERROR %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	task automatic compareBit(input string testName, input logic expected, input logic actual);
		if (expected !== actual) begin
			testErrors++;
			$display("ERROR %s: expected %b, actual %b", testName, expected, actual);
		end
	endtask

	task automatic finishTest(input string testName);
		errorCount += testErrors;
		if (testErrors == 0) begin
			passCount++;
			$display("PASS %s", testName);
		end else begin
			failCount++;
			$display("FAIL %s with %0d mismatches", testName, testErrors);
		end
		testErrors = 0;
	endtask

	// holds inclk for one cycle and returns right after the edge that samples it
	task automatic strobe(input blockT block, input blockT cipherKey);
		@(posedge clk);
		inclk <= 1'b1;
		plainIn <= block;
		keyIn <= cipherKey;
		@(posedge clk);
		inclk <= 1'b0;
	endtask

	// counts edges until outclk is seen, and flags a pulse that comes early or late
	task automatic waitForPulse(input string testName, input int expectEdges);
		int edges;
		edges = 0;
		waitName = {"outclk in test ", testName};
		do begin
			@(posedge clk);
			edges++;
			@(negedge clk);
			compareBit(testName, edges == expectEdges, outclk);
		end while (outclk !== 1'b1);
		waitName = "the next test";
	endtask

	task automatic testReset();
		@(negedge clk);
		compareBit("reset", 1'b0, outclk);
		compareBlock("reset", '0, cipherOut);
		waitName = "idle cycles after reset";
		repeat (12) begin
			@(negedge clk);
			compareBit("reset", 1'b0, outclk);
		end
		finishTest("reset");
	endtask

	task automatic testVectorC();
		strobe(plainC, keyC);
		waitForPulse("vectorC", blockEdges);
		compareBlock("vectorC", cipherC, cipherOut);
		finishTest("vectorC");
	endtask

	task automatic testVectorB();
		strobe(plainB, keyB);
		waitForPulse("vectorB", blockEdges);
		compareBlock("vectorB", cipherB, cipherOut);
		// out must hold after the pulse is gone
		repeat (5) begin
			@(negedge clk);
			compareBit("vectorB", 1'b0, outclk);
			compareBlock("vectorB", cipherB, cipherOut);
		end
		finishTest("vectorB");
	endtask

	task automatic testBusyIgnored();
		strobe(plainC, keyC);
		@(posedge clk);
		// this strobe is sampled three edges after the accepted one
		strobe(plainB, keyB);
		waitForPulse("busyIgnored", blockEdges - 3);
		compareBlock("busyIgnored", cipherC, cipherOut);
		// a wrongly accepted second block would pulse three edges later
		waitName = "quiet cycles after the busy strobe";
		repeat (15) begin
			@(negedge clk);
			compareBit("busyIgnored", 1'b0, outclk);
		end
		compareBlock("busyIgnored", cipherC, cipherOut);
		finishTest("busyIgnored");
	endtask

	task automatic testBackToBack();
		strobe(plainC, keyC);
		repeat (blockEdges - 1) @(posedge clk);
		// sampled at the same edge that raises the first pulse
		inclk <= 1'b1;
		plainIn <= plainB;
		keyIn <= keyB;
		@(posedge clk);
		inclk <= 1'b0;
		@(negedge clk);
		compareBit("backToBack", 1'b1, outclk);
		compareBlock("backToBack", cipherC, cipherOut);
		waitForPulse("backToBack", blockEdges);
		compareBlock("backToBack", cipherB, cipherOut);
		finishTest("backToBack");
	endtask

	initial begin
		rst = 1'b1;
		inclk = 1'b0;
		plainIn = '0;
		keyIn = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		testReset();
		testVectorC();
		testVectorB();
		testBusyIgnored();
		testBackToBack();

		$display("summary: %0d run, %0d passed, %0d failed, %0d mismatches, %0d assertion failures",
			passCount + failCount, passCount, failCount, errorCount,
			aesEncrypt_inst.roundSequencer_inst.seqChk.failures);
		if (failCount == 0 && aesEncrypt_inst.roundSequencer_inst.seqChk.failures == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: list.f
source/aesPkg.sv
source/sbox.sv
source/roundTransform.sv
source/keySchedule.sv
source/roundSequencer.sv
source/aesEncrypt.sv
bench/aesEncrypt_chk.sv
bench/aesEncryptTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP = aesEncryptTb
FILELIST = list.f
OBJDIR = obj_dir
LOG = sim.log
FAILMSG = tests failed
PASSMSG = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
